//--- logic/mipsIsaPkg.sv
package mipsIsaPkg;

////////////////////////////////////////
// field widths
////////////////////////////////////////
localparam int WORD_W    = 32;
localparam int OPCODE_W  = 6;
localparam int FUNCT_W   = 6;
localparam int REG_IDX_W = 5;   // register index and shamt
localparam int IMM_W     = 16;

typedef logic [WORD_W-1:0]    wordT;
typedef logic [OPCODE_W-1:0]  opcodeT;
typedef logic [FUNCT_W-1:0]   functT;
typedef logic [REG_IDX_W-1:0] regIdxT;
typedef logic [IMM_W-1:0]     immT;

////////////////////////////////////////
// instruction word layout
////////////////////////////////////////
// low half of an R-type word
typedef struct packed {
    regIdxT rd;
    regIdxT shamt;
    functT  funct;
} rTailT;

// low 16 bits read either as R-type fields or as the immediate
typedef union packed {
    rTailT r;
    immT   imm;
} instrTailT;

typedef struct packed {
    opcodeT    opcode;  // [31:26]
    regIdxT    rs;      // [25:21]
    regIdxT    rt;      // [20:16], also bltz/bgez select under regimm
    instrTailT tail;    // [15:0]
} instrFieldsT;

////////////////////////////////////////
// opcodes
////////////////////////////////////////
localparam opcodeT OP_RTYPE  = 6'b000000;
localparam opcodeT OP_REGIMM = 6'b000001;  // bltz / bgez
localparam opcodeT OP_J      = 6'b000010;
localparam opcodeT OP_JAL    = 6'b000011;
localparam opcodeT OP_BEQ    = 6'b000100;
localparam opcodeT OP_BNE    = 6'b000101;
localparam opcodeT OP_BLEZ   = 6'b000110;
localparam opcodeT OP_BGTZ   = 6'b000111;
localparam opcodeT OP_ADDI   = 6'b001000;
localparam opcodeT OP_SLTI   = 6'b001010;
localparam opcodeT OP_ANDI   = 6'b001100;
localparam opcodeT OP_ORI    = 6'b001101;
localparam opcodeT OP_XORI   = 6'b001110;
localparam opcodeT OP_MUL    = 6'b011100;
localparam opcodeT OP_LB     = 6'b100000;
localparam opcodeT OP_LH     = 6'b100001;
localparam opcodeT OP_LW     = 6'b100011;
localparam opcodeT OP_SB     = 6'b101000;
localparam opcodeT OP_SH     = 6'b101001;
localparam opcodeT OP_SW     = 6'b101011;

// R-type function codes
localparam functT FN_SLL = 6'b000000;
localparam functT FN_SRL = 6'b000010;
localparam functT FN_JR  = 6'b001000;
localparam functT FN_ADD = 6'b100000;
localparam functT FN_SUB = 6'b100010;
localparam functT FN_AND = 6'b100100;
localparam functT FN_OR  = 6'b100101;
localparam functT FN_XOR = 6'b100110;
localparam functT FN_NOR = 6'b100111;
localparam functT FN_SLT = 6'b101010;

endpackage

//--- logic/execPkg.sv
package execPkg;

import mipsIsaPkg::*;

////////////////////////////////////////
// ALU operation and branch kind
////////////////////////////////////////
localparam int ALU_OP_W  = 4;
localparam int BR_KIND_W = 3;

// numbering 0 to 10 as in the ALU control table
typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_MUL = 4'd2,    // low word of product
    ALU_AND = 4'd3,
    ALU_OR  = 4'd4,
    ALU_NOR = 4'd5,
    ALU_XOR = 4'd6,
    ALU_SLL = 4'd7,
    ALU_SRL = 4'd8,
    ALU_SLT = 4'd9,    // signed
    ALU_NOP = 4'd10    // j, jal, unknown opcodes
} aluOpT;

typedef enum logic [BR_KIND_W-1:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_GTZ  = 3'd3,
    BR_LEZ  = 3'd4,
    BR_LTZ  = 3'd5,
    BR_GEZ  = 3'd6
} branchKindT;

////////////////////////////////////////
// stage payloads
////////////////////////////////////////
// decode -> alu
typedef struct packed {
    aluOpT      aluOp;
    branchKindT branchKind;
    wordT       operandA;
    wordT       operandB;
    regIdxT     shamt;
} decodedT;

// alu -> branch resolve
typedef struct packed {
    wordT       result;
    branchKindT branchKind;
    logic       isZero;
    logic       isNegative;   // sign bit of result
} aluOutT;

// stage output
typedef struct packed {
    wordT result;
    logic branchTaken;
} execResultT;

endpackage

//--- logic/aluControl.sv
`timescale 1ns/1ps

module aluControl
    import mipsIsaPkg::*, execPkg::*;
(
    input  opcodeT     opcode,
    input  functT      funct,
    input  regIdxT     rtField,      // bltz / bgez select
    output aluOpT      aluOp,
    output branchKindT branchKind
);

    always_comb begin
        aluOp      = ALU_NOP;   // anything unlisted is a nop
        branchKind = BR_NONE;

        case (opcode)
            ////////////////////////////////////////
            // R-type, op from funct
            ////////////////////////////////////////
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_JR:   aluOp = ALU_ADD;   // rs + 0
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_NOR:  aluOp = ALU_NOR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: aluOp = ALU_NOP;
                endcase
            end

            // arithmetic outside R-type
            OP_ADDI: aluOp = ALU_ADD;
            OP_MUL:  aluOp = ALU_MUL;

            // loads and stores, base + offset
            OP_LW, OP_LH, OP_LB: aluOp = ALU_ADD;
            OP_SW, OP_SH, OP_SB: aluOp = ALU_ADD;

            ////////////////////////////////////////
            // branches, all compare by subtract
            ////////////////////////////////////////
            OP_REGIMM: begin
                case (rtField)
                    5'd0: begin
                        aluOp      = ALU_SUB;
                        branchKind = BR_LTZ;   // bltz
                    end
                    5'd1: begin
                        aluOp      = ALU_SUB;
                        branchKind = BR_GEZ;   // bgez
                    end
                    default: begin
                        aluOp      = ALU_NOP;
                        branchKind = BR_NONE;
                    end
                endcase
            end
            OP_BEQ: begin
                aluOp      = ALU_SUB;   // rs - rt
                branchKind = BR_EQ;
            end
            OP_BNE: begin
                aluOp      = ALU_SUB;
                branchKind = BR_NE;
            end
            OP_BGTZ: begin
                aluOp      = ALU_SUB;   // rs - 0
                branchKind = BR_GTZ;
            end
            OP_BLEZ: begin
                aluOp      = ALU_SUB;
                branchKind = BR_LEZ;
            end

            // jumps have no ALU work here
            OP_J, OP_JAL: aluOp = ALU_NOP;

            // immediate logic and compare
            OP_ANDI: aluOp = ALU_AND;
            OP_ORI:  aluOp = ALU_OR;
            OP_XORI: aluOp = ALU_XOR;
            OP_SLTI: aluOp = ALU_SLT;

            default: begin
                aluOp      = ALU_NOP;
                branchKind = BR_NONE;
            end
        endcase
    end

endmodule

//--- logic/instrDecode.sv
`timescale 1ns/1ps

module instrDecode
    import mipsIsaPkg::*, execPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  wordT        instrWord,
    input  wordT        rsValue,
    input  wordT        rtValue,
    input  aluOpT       aluOp,        // from aluControl, same cycle
    input  branchKindT  branchKind,   // from aluControl, same cycle
    output instrFieldsT fields,
    output logic        decValid,
    output decodedT     decoded
);

    wordT immExt;
    wordT operandA;
    wordT operandB;
    logic useImm;     // I-type arith or load/store
    logic zeroExt;    // logical immediates
    logic isJr;
    logic isShift;
    logic cmpZero;    // branch compares rs against zero

    // plain view of the word, fields go straight to the decoder
    assign fields = instrWord;

    ////////////////////////////////////////
    // immediate handling
    ////////////////////////////////////////
    always_comb begin
        useImm  = 1'b0;
        zeroExt = 1'b0;
        case (fields.opcode)
            OP_ADDI, OP_SLTI: useImm = 1'b1;
            OP_ANDI, OP_ORI, OP_XORI: begin
                useImm  = 1'b1;
                zeroExt = 1'b1;   // andi/ori/xori zero extend
            end
            OP_LW, OP_LH, OP_LB,
            OP_SW, OP_SH, OP_SB: useImm = 1'b1;   // address add
            default: useImm = 1'b0;
        endcase
    end

    assign immExt = zeroExt ? {{(WORD_W-IMM_W){1'b0}}, fields.tail.imm}
                            : {{(WORD_W-IMM_W){fields.tail.imm[IMM_W-1]}}, fields.tail.imm};

    ////////////////////////////////////////
    // operand select
    ////////////////////////////////////////
    assign isJr    = (fields.opcode == OP_RTYPE) && (fields.tail.r.funct == FN_JR);
    assign isShift = (aluOp == ALU_SLL) || (aluOp == ALU_SRL);
    assign cmpZero = branchKind inside {BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ};

    assign operandA = isShift ? rtValue : rsValue;   // shifts work on rt

    always_comb begin
        if (useImm)
            operandB = immExt;
        else if (isJr || cmpZero)
            operandB = '0;   // rs + 0 / rs - 0
        else
            operandB = rtValue;
    end

    // pipeline register, payload holds when idle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
            decoded  <= '0;
        end else begin
            decValid <= instrValid;
            if (instrValid) begin
                decoded.aluOp      <= aluOp;
                decoded.branchKind <= branchKind;
                decoded.operandA   <= operandA;
                decoded.operandB   <= operandB;
                decoded.shamt      <= fields.tail.r.shamt;
            end
        end
    end

endmodule

//--- logic/aluCore.sv
`timescale 1ns/1ps

module aluCore
    import mipsIsaPkg::*, execPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    decValid,
    input  decodedT decoded,
    output logic    aluValid,
    output aluOutT  aluOut
);

    wordT opA;
    wordT opB;
    wordT result;
    logic sltBit;

    assign opA = decoded.operandA;
    assign opB = decoded.operandB;

    assign sltBit = $signed(opA) < $signed(opB);   // signed compare

    ////////////////////////////////////////
    // operation mux
    ////////////////////////////////////////
    always_comb begin
        case (decoded.aluOp)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;   // also the branch compare
            ALU_MUL: result = opA * opB;   // 32b context keeps low word
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_NOR: result = ~(opA | opB);
            ALU_XOR: result = opA ^ opB;
            ALU_SLL: result = opA << decoded.shamt;   // opA is rt here
            ALU_SRL: result = opA >> decoded.shamt;   // logical, zero fill
            ALU_SLT: result = {{(WORD_W-1){1'b0}}, sltBit};
            ALU_NOP: result = '0;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluValid <= 1'b0;
            aluOut   <= '0;
        end else begin
            aluValid <= decValid;
            if (decValid) begin
                aluOut.result     <= result;
                aluOut.branchKind <= decoded.branchKind;   // rides along
                aluOut.isZero     <= (result == '0);
                aluOut.isNegative <= result[WORD_W-1];
            end
        end
    end

endmodule

//--- logic/branchResolve.sv
`timescale 1ns/1ps

module branchResolve
    import execPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       aluValid,
    input  aluOutT     aluOut,
    output logic       resultValid,
    output execResultT execOut
);

    logic taken;

    ////////////////////////////////////////
    // taken decision from flags
    ////////////////////////////////////////
    // flags come from rs - rt or rs - 0
    always_comb begin
        case (aluOut.branchKind)
            BR_EQ:   taken = aluOut.isZero;
            BR_NE:   taken = !aluOut.isZero;
            BR_GTZ:  taken = !aluOut.isNegative && !aluOut.isZero;
            BR_LEZ:  taken = aluOut.isNegative || aluOut.isZero;
            BR_LTZ:  taken = aluOut.isNegative;
            BR_GEZ:  taken = !aluOut.isNegative;
            BR_NONE: taken = 1'b0;   // not a branch
            default: taken = 1'b0;
        endcase
    end

    // final stage register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            execOut     <= '0;
        end else begin
            resultValid <= aluValid;
            if (aluValid) begin
                execOut.result      <= aluOut.result;
                execOut.branchTaken <= taken;
            end
        end
    end

endmodule

//--- logic/mipsExecUnit.sv
`timescale 1ns/1ps

module mipsExecUnit
    import mipsIsaPkg::*, execPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  wordT       instrWord,
    input  wordT       rsValue,
    input  wordT       rtValue,
    output logic       resultValid,   // 3 clocks after instrValid
    output execResultT execOut
);

    ////////////////////////////////////////
    // stage wiring
    ////////////////////////////////////////
    instrFieldsT fields;
    aluOpT       aluOp;
    branchKindT  branchKind;
    logic        decValid;
    decodedT     decoded;
    logic        aluValid;
    aluOutT      aluOut;

    instrDecode decode0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .aluOp      (aluOp),
        .branchKind (branchKind),
        .fields     (fields),
        .decValid   (decValid),
        .decoded    (decoded)
    );

    // combinational, sits beside decode
    aluControl aluCtrl0 (
        .opcode     (fields.opcode),
        .funct      (fields.tail.r.funct),
        .rtField    (fields.rt),
        .aluOp      (aluOp),
        .branchKind (branchKind)
    );

    aluCore alu0 (
        .clk      (clk),
        .rstN     (rstN),
        .decValid (decValid),
        .decoded  (decoded),
        .aluValid (aluValid),
        .aluOut   (aluOut)
    );

    branchResolve branch0 (
        .clk         (clk),
        .rstN        (rstN),
        .aluValid    (aluValid),
        .aluOut      (aluOut),
        .resultValid (resultValid),
        .execOut     (execOut)
    );

endmodule

//--- testbench/execRefModel.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

////////////////////////////////////////
// expected execute result per instruction
////////////////////////////////////////
function automatic execResultT expectExec(input wordT instr, input wordT rs, input wordT rt);
    opcodeT     op;
    functT      fn;
    regIdxT     rtSel;
    regIdxT     sh;
    wordT       sImm;
    wordT       zImm;
    execResultT want;
    op    = instr[31:26];
    rtSel = instr[20:16];              // bltz / bgez pick under regimm
    sh    = instr[10:6];
    fn    = instr[5:0];
    sImm  = {{16{instr[15]}}, instr[15:0]};
    zImm  = {16'h0000, instr[15:0]};   // andi, ori, xori
    want  = '0;                        // nops stay at zero, not taken
    case (op)
        OP_RTYPE: begin
            case (fn)
                FN_ADD:  want.result = rs + rt;
                FN_SUB:  want.result = rs - rt;
                FN_AND:  want.result = rs & rt;
                FN_OR:   want.result = rs | rt;
                FN_NOR:  want.result = ~(rs | rt);
                FN_XOR:  want.result = rs ^ rt;
                FN_SLT:  want.result = {31'd0, $signed(rs) < $signed(rt)};
                FN_SLL:  want.result = rt << sh;
                FN_SRL:  want.result = rt >> sh;
                FN_JR:   want.result = rs;   // rs plus zero
                default: want.result = '0;
            endcase
        end
        OP_ADDI, OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB: want.result = rs + sImm;
        OP_SLTI: want.result = {31'd0, $signed(rs) < $signed(sImm)};
        OP_ANDI: want.result = rs & zImm;
        OP_ORI:  want.result = rs | zImm;
        OP_XORI: want.result = rs ^ zImm;
        OP_MUL:  want.result = rs * rt;      // low word only
        OP_BEQ: begin
            want.result      = rs - rt;
            want.branchTaken = (rs == rt);
        end
        OP_BNE: begin
            want.result      = rs - rt;
            want.branchTaken = (rs != rt);
        end
        OP_BGTZ: begin
            want.result      = rs;
            want.branchTaken = $signed(rs) > 0;
        end
        OP_BLEZ: begin
            want.result      = rs;
            want.branchTaken = $signed(rs) <= 0;
        end
        OP_REGIMM: begin
            if (rtSel == 5'd0 || rtSel == 5'd1) begin
                want.result      = rs;
                want.branchTaken = (rtSel == 5'd0) ? ($signed(rs) < 0) : ($signed(rs) >= 0);
            end
        end
        default: want = '0;   // j, jal, undefined
    endcase
    return want;
endfunction

`endif

//--- testbench/execTb.sv
`timescale 1ns/1ps

module execTb
    import mipsIsaPkg::*, execPkg::*;
;

    `include "execRefModel.svh"

    localparam logic [31:0] SEED = 32'hd7b0_3175;
    localparam int CLK_PERIOD   = 10;
    localparam int RST_CYCLES   = 8;
    localparam int IDLE_CYCLES  = 10;
    localparam int REPS         = 4;    // per R-type funct and I-type opcode
    localparam int BR_PAIRS     = 5;
    localparam int NOP_REPS     = 3;
    localparam int B2B_COUNT    = 40;
    localparam int NUM_TESTS    = 6;
    localparam int DRAIN_CYCLES = 6;
    localparam int TOTAL_INSTR  = 10*REPS + 12*REPS + 6*BR_PAIRS + 4*NOP_REPS + B2B_COUNT;
    // gapped issue costs two cycles per instruction
    localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES + 2*TOTAL_INSTR
                                   + NUM_TESTS*DRAIN_CYCLES + 20;

    logic       clk;
    logic       rstN;
    logic       instrValid;
    wordT       instrWord;
    wordT       rsValue;
    wordT       rtValue;
    logic       resultValid;
    execResultT execOut;

    execResultT expQ[$];      // expected results in issue order
    logic [2:0] validHist;    // instrValid seen at the last three edges
    int         errors;
    int         checks;
    int         testCount;
    int         testErrBase;

    functT  rFuncts[$] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_NOR, FN_XOR,
                           FN_SLT, FN_SLL, FN_SRL, FN_JR};
    opcodeT iOps[$]    = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_MUL,
                           OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB};
    opcodeT brOps[$]   = '{OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM};
    opcodeT nopOps[$]  = '{OP_J, OP_JAL, 6'b111111, OP_REGIMM};   // regimm with bad rt

    mipsExecUnit dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instrWord   (instrWord),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .resultValid (resultValid),
        .execOut     (execOut)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic compareValue(input string name, input wordT want, input wordT got);
        checks++;
        assert (got == want) else begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, want, got);
            errors++;
        end
    endtask

    function automatic wordT rWord(input functT fn);
        return {OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), fn};
    endfunction

    function automatic wordT iWord(input opcodeT op, input regIdxT rtSel);
        return {op, 5'($urandom), rtSel, 16'($urandom)};
    endfunction

    task automatic issue(input wordT instr, input wordT rs, input wordT rt);
        instrValid = 1'b1;
        instrWord  = instr;
        rsValue    = rs;
        rtValue    = rt;
        expQ.push_back(expectExec(instr, rs, rt));
        @(negedge clk);
    endtask

    task automatic pause(input int cycles);
        instrValid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        pause(1);
        while (expQ.size() != 0) @(negedge clk);   // drain outstanding results
        pause(1);
        testCount++;
        $display("test %s done, %0d errors", name, errors - testErrBase);
        testErrBase = errors;
    endtask

    // equal, negative, positive and zero differences
    task automatic branchSet(input opcodeT op, input regIdxT rtSel);
        wordT r;
        wordT rsVals[$];
        wordT rtVals[$];
        r      = $urandom;
        rsVals = '{r, 32'hffff_fffd, 32'd7, 32'd0, 32'h8000_0000};   // -3 in slot 1
        rtVals = '{r, 32'd4, 32'd2, 32'd0, $urandom};
        for (int k = 0; k < BR_PAIRS; k++) begin
            issue(iWord(op, rtSel), rsVals[k], rtVals[k]);
            pause(1);
        end
    endtask

    ////////////////////////////////////////
    // output checker on pre-edge values
    ////////////////////////////////////////
    always @(posedge clk) begin
        execResultT head;
        if (!rstN) begin
            validHist = '0;
        end else begin
            compareValue("resultValid", 32'(validHist[2]), 32'(resultValid));   // 3 clock latency
            if (resultValid) begin
                checks++;
                assert (expQ.size() != 0) else begin
                    $display("result at %0t arrived with no instruction outstanding", $time);
                    errors++;
                end
                if (expQ.size() != 0) begin
                    head = expQ.pop_front();
                    compareValue("execOut.result", head.result, execOut.result);
                    compareValue("execOut.branchTaken", 32'(head.branchTaken),
                                 32'(execOut.branchTaken));
                end
            end
            validHist = {validHist[1:0], instrValid};
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instrWord   = '0;
        rsValue     = '0;
        rtValue     = '0;
        errors      = 0;
        checks      = 0;
        testCount   = 0;
        testErrBase = 0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        pause(IDLE_CYCLES);   // resultValid must stay low
        compareValue("execOut.result", 32'd0, execOut.result);
        finishTest("idle after reset");

        foreach (rFuncts[f]) begin
            for (int n = 0; n < REPS; n++) begin
                issue(rWord(rFuncts[f]), $urandom, $urandom);
                pause(1);
            end
        end
        finishTest("r-type");

        foreach (iOps[o]) begin
            for (int n = 0; n < REPS; n++) begin
                issue(iWord(iOps[o], 5'($urandom)), $urandom, $urandom);
                pause(1);
            end
        end
        finishTest("i-type and memory");

        branchSet(OP_BEQ, 5'($urandom));
        branchSet(OP_BNE, 5'($urandom));
        branchSet(OP_BGTZ, 5'($urandom));
        branchSet(OP_BLEZ, 5'($urandom));
        branchSet(OP_REGIMM, 5'd0);   // bltz
        branchSet(OP_REGIMM, 5'd1);   // bgez
        finishTest("branches");

        foreach (nopOps[o]) begin
            for (int n = 0; n < NOP_REPS; n++) begin
                issue(iWord(nopOps[o], 5'd9), $urandom, $urandom);
                pause(1);
            end
        end
        finishTest("no-operations");

        // one instruction every cycle
        for (int n = 0; n < B2B_COUNT; n++) begin
            case ($urandom_range(3, 0))
                0: issue(rWord(rFuncts[$urandom_range(9, 0)]), $urandom, $urandom);
                1: issue(iWord(iOps[$urandom_range(11, 0)], 5'($urandom)), $urandom, $urandom);
                2: issue(iWord(brOps[$urandom_range(4, 0)], 5'($urandom_range(1, 0))),
                         $urandom, $urandom);
                default: issue(iWord(nopOps[$urandom_range(2, 0)], 5'd9), $urandom, $urandom);
            endcase
        end
        finishTest("back-to-back");

        $display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
logic/mipsIsaPkg.sv
logic/execPkg.sv
logic/aluControl.sv
logic/instrDecode.sv
logic/aluCore.sv
logic/branchResolve.sv
logic/mipsExecUnit.sv
testbench/execTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module execTb -o execSim &&
./obj_dir/execSim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
